// File: flist.f
+incdir+sim
rtl/video_pkg.sv
rtl/ycbcr_capture.sv
rtl/ycbcr_to_rgb565.sv
rtl/frame_sequencer.sv
rtl/frame_buffer.sv
rtl/video_capture_top.sv
sim/video_capture_properties.sv
sim/tb_video_capture.sv

// File: Makefile
# Verilator flow for the frame grabber testbench

TOP = tb_video_capture

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -Wall -f flist.f --top-module $(TOP)

obj_dir/V$(TOP): flist.f rtl/*.sv sim/*.sv sim/*.svh
	verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module $(TOP)

# pass only when the run prints the pass line
sim: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf obj_dir

// File: sim/tb_video_model.svh
// reference model of the grabber, included inside the testbench module
// keeps the expected frame buffer, the bank being filled and the bank finished last
// YCbCr to RGB565 worked out in plain integers from the fixed-point rules
`ifndef TB_VIDEO_MODEL_SVH
`define TB_VIDEO_MODEL_SVH

localparam int bank_words = mem_words / 2;

rgb565_t exp_mem [0:mem_words-1];   // expected memory contents
logic    exp_wr_bank;               // bank being filled
logic    exp_rd_bank;               // bank finished last, host side
int      exp_offset;                // next pixel slot in the bank

// saturate a sum, then take width bits from lsb up
function automatic int clamp_bits(input int v, input int lsb, input int width);
	int ones;
	ones = (1 << width) - 1;
	if (v < 0)
		return 0;                      // negative sum
	else if (v >= (1 << 18))
		return ones;                   // beyond the 2.8 range
	else
		return (v >> lsb) & ones;
endfunction

function automatic rgb565_t convert_pixel(input byte_t cb, input byte_t y, input byte_t cr);
	int lum, cbt, crt, r, g, b;
	lum = 298 * (4 * int'(y) - 64);     // 1.164
	cbt = 4 * int'(cb) - 512;
	crt = 4 * int'(cr) - 512;
	r   = lum + 408 * crt;              // 1.596
	g   = lum - 208 * crt - 100 * cbt;  // 0.813 and 0.392
	b   = lum + 516 * cbt;              // 2.017
	return rgb565_t'((clamp_bits(r, 13, 5) << 11) | (clamp_bits(g, 12, 6) << 5)
		| clamp_bits(b, 13, 5));
endfunction

function automatic void reset_model();
	exp_wr_bank = 1'b1;    // toggles to 0 on the first field
	exp_rd_bank = 1'b1;
	exp_offset  = 0;
endfunction

function automatic void start_field();
	exp_wr_bank = ~exp_wr_bank;
	exp_offset  = 0;
endfunction

// one kept pixel, placed at the next slot of the filling bank
function automatic void store_pixel(input byte_t cb, input byte_t y, input byte_t cr);
	exp_mem[(exp_wr_bank ? bank_words : 0) + exp_offset] = convert_pixel(cb, y, cr);
	exp_offset++;
endfunction

function automatic void finish_field();
	exp_rd_bank = exp_wr_bank;   // host now sees this bank
endfunction

function automatic rgb565_t expected_read(input int offset);
	return exp_mem[(exp_rd_bank ? bank_words : 0) + offset];
endfunction

`endif

// File: sim/tb_video_capture.sv
// testbench for the frame grabber top level
// random odd and even fields, full bank readback after each field,
// random host reads while the next field is captured; model in the .svh
`timescale 1ns/1ps

module tb_video_capture
	import video_pkg::*;
();

	//----------------------------------------
	// stimulus geometry and run limit
	//----------------------------------------
	localparam int addr_w           = 16;
	localparam int mem_words        = 2 ** addr_w;
	localparam int reset_cycles     = 5;
	localparam int line_bytes       = 32;
	localparam int lines            = 8;
	localparam int hblank           = 8;
	localparam int vblank           = 10;   // vref high before the first line
	localparam int field_gap        = 6;    // vref low between fields
	localparam int n_frames         = 3;    // odd + even field each
	localparam int burst_reads      = 16;   // host reads during capture
	localparam int irq_wait         = 8;
	localparam int pixels_per_field = (lines / 2) * (line_bytes / 4);
	localparam int field_cycles     = field_gap + vblank + lines * (line_bytes + hblank) + 1;
	localparam int frame_reads      = 2 * pixels_per_field + burst_reads;
	localparam int max_cycles       = 2 * (reset_cycles
		+ n_frames * (2 * field_cycles + irq_wait + frame_reads * 8));

	logic              clk_llc = 1'b0;
	logic              resetx;
	logic              vref, href, odd;
	byte_t             vpo;
	logic              rd_req;
	logic [addr_w-2:0] rd_adr;
	rgb565_t           rd_data;
	logic              rd_valid, host_busy;
	logic              irq0, irq1;
	int                seed;
	int                errors = 0;
	int                cycles = 0;

	`include "tb_video_model.svh"

	video_capture_top #(.addr_w(addr_w), .mem_words(mem_words)) video_capture_top_inst (
		.clk_llc   (clk_llc),
		.resetx    (resetx),
		.vref      (vref),
		.href      (href),
		.odd       (odd),
		.vpo       (vpo),
		.rd_req    (rd_req),
		.rd_adr    (rd_adr),
		.rd_data   (rd_data),
		.rd_valid  (rd_valid),
		.host_busy (host_busy),
		.irq0      (irq0),
		.irq1      (irq1)
	);

	always #4 clk_llc = ~clk_llc;   // 8 ns

	always @(posedge clk_llc)
	begin
		cycles <= cycles + 1;
		if (cycles > max_cycles)
		begin
			$display("run passed %0d cycles, a wait for the DUT never ended", max_cycles);
			$display("TEST FAILED");
			$fatal(1, "timeout");
		end
	end

	//----------------------------------------
	// compare tasks
	//----------------------------------------
	task automatic compare_pixel(input rgb565_t got, input rgb565_t exp, input string what);
		if (got !== exp)
		begin
			errors++;
			$display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
			$display("TEST FAILED");
			$fatal(1, "pixel mismatch");
		end
	endtask

	task automatic compare_flag(input logic got, input logic exp, input string what);
		if (got !== exp)
		begin
			errors++;
			$display("** Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
			$display("TEST FAILED");
			$fatal(1, "flag mismatch");
		end
	endtask

	//----------------------------------------
	// video side
	//----------------------------------------
	// a quarter of the bytes are extremes, pushes the sums into saturation
	function automatic byte_t random_byte();
		int r;
		r = $random(seed);
		case (r & 7)
			0:       return 8'h00;
			1:       return 8'hff;
			default: return byte_t'(r >>> 8);
		endcase
	endfunction

	// no interrupt may show while a field is being sent
	task automatic step_no_irq();
		@(negedge clk_llc);
		compare_flag(irq0, 1'b0, "irq0 inside field");
		compare_flag(irq1, 1'b0, "irq1 inside field");
	endtask

	task automatic drive_field(input logic odd_flag);
		byte_t b, cb_s, y_s;
		odd = odd_flag;
		repeat (field_gap) step_no_irq();
		vref = 1'b1;                          // odd already stable
		if (odd_flag)
			start_field();
		repeat (vblank) step_no_irq();
		for (int line = 1; line <= lines; line++)
		begin
			href = 1'b1;
			for (int i = 0; i < line_bytes; i++)
			begin
				b   = random_byte();
				vpo = b;
				if (odd_flag && (line % 2 == 0))    // second, fourth ... line
				begin
					case (i % 4)
						0:       cb_s = b;
						1:       y_s  = b;
						2:       store_pixel(cb_s, y_s, b);
						default: ;                     // Y1 dropped
					endcase
				end
				step_no_irq();
			end
			href = 1'b0;
			for (int i = 0; i < hblank; i++)
			begin
				vpo = random_byte();                 // junk outside href
				step_no_irq();
			end
		end
		vref = 1'b0;
		if (odd_flag)
			finish_field();
		@(negedge clk_llc);
	endtask

	// irq for the finished bank, irq0 for bank 0
	task automatic wait_irq();
		int n;
		n = 0;
		while (!(irq0 || irq1) && n < irq_wait)
		begin
			@(negedge clk_llc);
			n++;
		end
		compare_flag(irq0, ~exp_rd_bank, "irq0 after field");
		compare_flag(irq1, exp_rd_bank, "irq1 after field");
	endtask

	//----------------------------------------
	// host side
	//----------------------------------------
	task automatic host_read(input int offset);
		rgb565_t exp;
		int      lat;
		exp = expected_read(offset);
		while (host_busy)
			@(negedge clk_llc);
		rd_req = 1'b1;
		rd_adr = offset[addr_w-2:0];
		@(negedge clk_llc);
		rd_req = 1'b0;
		compare_flag(host_busy, 1'b1, "host_busy after rd_req");
		lat = 1;
		while (!rd_valid && lat < 3)
		begin
			@(negedge clk_llc);
			lat++;
		end
		compare_flag(rd_valid, 1'b1, "rd_valid within 3 cycles of rd_req");
		compare_pixel(rd_data, exp, $sformatf("bank %0d offset %0d", exp_rd_bank, offset));
	endtask

	task automatic read_bank();
		for (int i = 0; i < pixels_per_field; i++)
			host_read(i);
	endtask

	// random offsets and gaps, collides with video writes now and then
	task automatic random_reads(input int count);
		int gap;
		for (int i = 0; i < count; i++)
		begin
			gap = $random(seed) & 3;
			repeat (gap) @(negedge clk_llc);
			host_read(int'({$random(seed)} % pixels_per_field));
		end
	endtask

	//----------------------------------------
	// main sequence
	//----------------------------------------
	initial
	begin
		seed   = 60;
		resetx = 1'b0;
		vref   = 1'b0;
		href   = 1'b0;
		odd    = 1'b0;
		vpo    = 8'h00;
		rd_req = 1'b0;
		rd_adr = '0;
		reset_model();
		repeat (reset_cycles) @(negedge clk_llc);
		resetx = 1'b1;
		compare_flag(rd_valid, 1'b0, "rd_valid after reset");
		compare_flag(host_busy, 1'b0, "host_busy after reset");
		compare_flag(irq0, 1'b0, "irq0 after reset");
		compare_flag(irq1, 1'b0, "irq1 after reset");

		for (int f = 0; f < n_frames; f++)
		begin
			if (f == 0)
				drive_field(1'b1);                  // nothing finished yet, no reads
			else
			begin
				fork
					drive_field(1'b1);
					random_reads(burst_reads);      // last frame's bank
				join
			end
			wait_irq();
			read_bank();
			drive_field(1'b0);                      // even field, memory untouched
			read_bank();
			$display("frame %0d read back from bank %0d", f, exp_rd_bank);
		end

		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// File: sim/video_capture_properties.sv
// concurrent checks on the host read port and the field interrupts
// bound into frame_buffer for the host side and into frame_sequencer for the irqs
// ports a target does not have are tied low in its bind
`timescale 1ns/1ps

module video_capture_properties
(
	input logic clk_llc,
	input logic resetx,
	input logic rd_req,
	input logic rd_valid,
	input logic host_busy,
	input logic irq0,
	input logic irq1
);

	//----------------------------------------
	// host port
	//----------------------------------------
	read_done: assert property (@(posedge clk_llc) disable iff (!resetx)
		$past(rd_req, 3) |-> (rd_valid || $past(rd_valid)))
		else $error("no rd_valid 2 or 3 cycles after rd_req");

	read_source: assert property (@(posedge clk_llc) disable iff (!resetx)
		rd_valid |-> ($past(rd_req, 2) || $past(rd_req, 3)))
		else $error("rd_valid without a matching rd_req");

	req_when_free: assert property (@(posedge clk_llc) disable iff (!resetx)
		rd_req |-> !host_busy)
		else $error("rd_req while host_busy");

	//----------------------------------------
	// interrupts, exactly two cycles, one bank at a time
	//----------------------------------------
	// pulses of the two banks never overlap or touch
	irq_exclusive: assert property (@(posedge clk_llc) disable iff (!resetx)
		!((irq0 || $past(irq0)) && (irq1 || $past(irq1))))
		else $error("irq0 and irq1 pulses overlap");

	irq0_short: assert property (@(posedge clk_llc) disable iff (!resetx)
		$fell(irq0) |-> ($past(irq0, 2) && !$past(irq0, 3)))
		else $error("irq0 pulse not two cycles");

	irq0_long: assert property (@(posedge clk_llc) disable iff (!resetx)
		(irq0 && $past(irq0)) |-> !$past(irq0, 2))
		else $error("irq0 pulse longer than two cycles");

	irq1_short: assert property (@(posedge clk_llc) disable iff (!resetx)
		$fell(irq1) |-> ($past(irq1, 2) && !$past(irq1, 3)))
		else $error("irq1 pulse not two cycles");

	irq1_long: assert property (@(posedge clk_llc) disable iff (!resetx)
		(irq1 && $past(irq1)) |-> !$past(irq1, 2))
		else $error("irq1 pulse longer than two cycles");

endmodule

bind frame_buffer video_capture_properties host_port_props (
	.clk_llc   (clk_llc),
	.resetx    (resetx),
	.rd_req    (rd_req),
	.rd_valid  (rd_valid),
	.host_busy (host_busy),
	.irq0      (1'b0),
	.irq1      (1'b0)
);

bind frame_sequencer video_capture_properties irq_props (
	.clk_llc   (clk_llc),
	.resetx    (resetx),
	.rd_req    (1'b0),
	.rd_valid  (1'b0),
	.host_busy (1'b0),
	.irq0      (irq0),
	.irq1      (irq1)
);

// File: rtl/video_capture_top.sv
// frame grabber top level, one clock domain
// capture -> colour conversion -> sequencer -> two-bank frame buffer
// host reads the last finished bank, irq0/irq1 flag which bank that is
`timescale 1ns/1ps

module video_capture_top #(
	parameter int addr_w    = 16,
	parameter int mem_words = 2 ** addr_w
)
(
	input  logic              clk_llc,
	input  logic              resetx,
	input  logic              vref,
	input  logic              href,
	input  logic              odd,
	input  logic [7:0]        vpo,
	input  logic              rd_req,     // one-cycle strobe, only when not busy
	input  logic [addr_w-2:0] rd_adr,     // word offset inside the bank
	output logic [15:0]       rd_data,
	output logic              rd_valid,
	output logic              host_busy,
	output logic              irq0,
	output logic              irq1
);

	// capture -> conversion
	logic              pix_stb;
	logic [7:0]        cb, y, cr;
	logic              field_start, field_end;
	// conversion -> sequencer
	logic              rgb_stb;
	logic [15:0]       rgb;
	// sequencer -> frame buffer
	logic              wr_stb;
	logic [addr_w-1:0] wr_adr;
	logic [15:0]       wr_data;
	logic              rd_bank;

	ycbcr_capture capture_inst (
		.clk_llc     (clk_llc),
		.resetx      (resetx),
		.vref        (vref),
		.href        (href),
		.odd         (odd),
		.vpo         (vpo),
		.pix_stb     (pix_stb),
		.cb          (cb),
		.y           (y),
		.cr          (cr),
		.field_start (field_start),
		.field_end   (field_end)
	);

	ycbcr_to_rgb565 convert_inst (
		.clk_llc (clk_llc),
		.resetx  (resetx),
		.pix_stb (pix_stb),
		.cb      (cb),
		.y       (y),
		.cr      (cr),
		.rgb_stb (rgb_stb),
		.rgb     (rgb)
	);

	frame_sequencer #(.addr_w(addr_w)) sequencer_inst (
		.clk_llc     (clk_llc),
		.resetx      (resetx),
		.field_start (field_start),
		.field_end   (field_end),
		.rgb_stb     (rgb_stb),
		.rgb         (rgb),
		.wr_stb      (wr_stb),
		.wr_adr      (wr_adr),
		.wr_data     (wr_data),
		.rd_bank     (rd_bank),
		.irq0        (irq0),
		.irq1        (irq1)
	);

	frame_buffer #(.addr_w(addr_w), .mem_words(mem_words)) buffer_inst (
		.clk_llc   (clk_llc),
		.resetx    (resetx),
		.wr_stb    (wr_stb),
		.wr_adr    (wr_adr),
		.wr_data   (wr_data),
		.rd_bank   (rd_bank),
		.rd_req    (rd_req),
		.rd_adr    (rd_adr),
		.rd_data   (rd_data),
		.rd_valid  (rd_valid),
		.host_busy (host_busy)
	);

endmodule

// File: rtl/frame_buffer.sv
// single-port frame memory shared by video writes and host reads
// video always wins, a host request waits as pending until the memory is free
// read latency 2 cycles, 3 when it collides with a write
`timescale 1ns/1ps

module frame_buffer
	import video_pkg::*;
#(
	parameter int addr_w    = 16,
	parameter int mem_words = 2 ** addr_w
)
(
	input  logic              clk_llc,
	input  logic              resetx,
	input  logic              wr_stb,
	input  logic [addr_w-1:0] wr_adr,
	input  rgb565_t           wr_data,
	input  logic              rd_bank,
	input  logic              rd_req,
	input  logic [addr_w-2:0] rd_adr,
	output rgb565_t           rd_data,
	output logic              rd_valid,
	output logic              host_busy
);

	rgb565_t           mem [0:mem_words-1];
	arb_state_t        state, state_nxt;
	logic              pend;          // host request not yet served
	logic [addr_w-1:0] wr_adr_q;
	rgb565_t           wr_data_q;
	logic [addr_w-1:0] rd_adr_q;      // bank + offset of the host read

	//----------------------------------------
	// arbitration FSM
	//----------------------------------------
	always_comb
	begin
		state_nxt = idle;
		case (state)
			idle, video_write:
				if (wr_stb)
					state_nxt = video_write;
				else if (pend | rd_req)
					state_nxt = host_read;
			host_read:
				if (wr_stb)
					state_nxt = video_write;   // read already done this cycle
			default:
				state_nxt = idle;
		endcase
	end

	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
		begin
			state     <= idle;
			pend      <= 1'b0;
			rd_valid  <= 1'b0;
			host_busy <= 1'b0;
		end
		else
		begin
			state    <= state_nxt;
			rd_valid <= (state == host_read);
			if (state_nxt == host_read)
				pend <= 1'b0;
			else if (rd_req)
				pend <= 1'b1;
			if (rd_req)
				host_busy <= 1'b1;
			else if (state == host_read)
				host_busy <= 1'b0;        // drops as rd_valid rises
		end
	end

	// held request and write payload
	always_ff @(posedge clk_llc)
	begin
		if (wr_stb)
		begin
			wr_adr_q  <= wr_adr;
			wr_data_q <= wr_data;
		end
		if (rd_req)
			rd_adr_q <= {rd_bank, rd_adr};
	end

	//----------------------------------------
	// memory port
	//----------------------------------------
	always_ff @(posedge clk_llc)
	begin
		if (state == video_write)
			mem[wr_adr_q] <= wr_data_q;
		else if (state == host_read)
			rd_data <= mem[rd_adr_q];
	end

endmodule

// File: rtl/frame_sequencer.sv
// places converted pixels in the two-bank frame buffer
// bank toggles per captured field, offset counts pixels inside the field
// remembers the last finished bank for the host and raises its interrupt
`timescale 1ns/1ps

module frame_sequencer
	import video_pkg::*;
#(
	parameter int addr_w = 16
)
(
	input  logic              clk_llc,
	input  logic              resetx,
	input  logic              field_start,
	input  logic              field_end,
	input  logic              rgb_stb,
	input  rgb565_t           rgb,
	output logic              wr_stb,
	output logic [addr_w-1:0] wr_adr,
	output rgb565_t           wr_data,
	output logic              rd_bank,   // bank completed last
	output logic              irq0,
	output logic              irq1
);

	logic              wr_bank;
	logic [addr_w-2:0] offset;      // word offset inside the bank
	logic [1:0]        irq_sh;      // two-cycle pulse shaper
	logic              irq_on;

	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
		begin
			wr_bank <= 1'b1;     // first field lands in bank 0
			offset  <= '0;
			wr_stb  <= 1'b0;
			rd_bank <= 1'b1;
			irq_sh  <= 2'b00;
		end
		else
		begin
			wr_stb <= rgb_stb;
			irq_sh <= {irq_sh[0], field_end};
			if (field_start)
			begin
				wr_bank <= ~wr_bank;
				offset  <= '0;
			end
			else if (rgb_stb)
				offset <= offset + 1'b1;
			if (field_end)
				rd_bank <= wr_bank;   // hand the finished bank to the host
		end
	end

	// write payload, sampled with the strobe
	always_ff @(posedge clk_llc)
	begin
		if (rgb_stb)
		begin
			wr_adr  <= {wr_bank, offset};
			wr_data <= rgb;
		end
	end

	// rd_bank already names the finished bank while the pulse runs
	assign irq_on = irq_sh[0] | irq_sh[1];
	assign irq0   = irq_on & ~rd_bank;
	assign irq1   = irq_on & rd_bank;

endmodule

// File: rtl/ycbcr_to_rgb565.sv
// YCbCr to RGB565 colour conversion, fixed point 2.8 coefficients
// two register stages: products, then sums; saturation packs the sums
// one sample per cycle, rgb_stb follows pix_stb by two cycles
`timescale 1ns/1ps

module ycbcr_to_rgb565
	import video_pkg::*;
(
	input  logic    clk_llc,
	input  logic    resetx,
	input  logic    pix_stb,
	input  byte_t   cb,
	input  byte_t   y,
	input  byte_t   cr,
	output logic    rgb_stb,
	output rgb565_t rgb
);

	conv_t y_term, cb_term, cr_term;            // offset-removed samples
	conv_t p_y, p_cr_r, p_cr_g, p_cb_g, p_cb_b;  // stage one
	conv_t sum_r, sum_g, sum_b;                  // stage two
	logic  s1_stb, s2_stb;
	logic [5:0] r6, g6, b6;

	// clamp a sum to its top 6 result bits
	function automatic logic [5:0] sat_top6(conv_t v);
		if (v[20])
			return 6'b000000;       // negative
		else if (v[19] | v[18])
			return 6'b111111;       // overflow
		else
			return v[17:12];
	endfunction

	// shift left by two, then remove the offset
	assign y_term  = conv_t'({y, 2'b00}) - luma_offset;
	assign cb_term = conv_t'({cb, 2'b00}) - chroma_offset;
	assign cr_term = conv_t'({cr, 2'b00}) - chroma_offset;

	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
		begin
			s1_stb <= 1'b0;
			s2_stb <= 1'b0;
		end
		else
		begin
			s1_stb <= pix_stb;
			s2_stb <= s1_stb;
		end
	end

	//----------------------------------------
	// stage one, products
	//----------------------------------------
	always_ff @(posedge clk_llc)
	begin
		if (pix_stb)
		begin
			p_y    <= conv_t'(coef_y) * y_term;
			p_cr_r <= conv_t'(coef_cr_r) * cr_term;
			p_cr_g <= conv_t'(coef_cr_g) * cr_term;
			p_cb_g <= conv_t'(coef_cb_g) * cb_term;
			p_cb_b <= conv_t'(coef_cb_b) * cb_term;
		end
	end

	//----------------------------------------
	// stage two, sums
	//----------------------------------------
	always_ff @(posedge clk_llc)
	begin
		if (s1_stb)
		begin
			sum_r <= p_y + p_cr_r;
			sum_g <= p_y - p_cr_g - p_cb_g;
			sum_b <= p_y + p_cb_b;
		end
	end

	assign r6 = sat_top6(sum_r);
	assign g6 = sat_top6(sum_g);
	assign b6 = sat_top6(sum_b);

	assign rgb_stb = s2_stb;
	assign rgb     = {r6[5:1], g6, b6[5:1]};   // red, blue keep bits 17..13

endmodule

// File: rtl/ycbcr_capture.sv
// front end of the grabber: takes the 8-bit YCbCr 4:2:2 byte stream,
// keeps odd fields only, every second line and one pixel per 4-byte group
// emits one pix_stb per kept pixel with its cb, y, cr
`timescale 1ns/1ps

module ycbcr_capture
	import video_pkg::*;
(
	input  logic  clk_llc,
	input  logic  resetx,
	input  logic  vref,         // vertical sync, high in active field
	input  logic  href,         // horizontal sync, high in active line
	input  logic  odd,          // field parity
	input  byte_t vpo,          // video byte
	output logic  pix_stb,
	output byte_t cb,
	output byte_t y,
	output byte_t cr,
	output logic  field_start,
	output logic  field_end
);

	logic       href_d;      // href of the previous cycle
	logic       field_d;     // field_act of the previous cycle
	logic       field_act;
	logic       href_rise;
	logic       line_par;    // lines started in this field, mod 2
	logic       keep_now;    // current byte belongs to a kept line
	logic [1:0] byte_cnt;    // Cb, Y0, Cr, Y1

	assign field_act = vref & odd;
	assign href_rise = href & ~href_d;

	// parity before this line's own toggle, so lines 2, 4, ... pass
	// on the rising cycle line_par still holds the old value
	assign keep_now = field_act & href & (href_rise ? line_par : ~line_par);

	//----------------------------------------
	// sync edges and line parity
	//----------------------------------------
	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
		begin
			href_d      <= 1'b0;
			field_d     <= 1'b0;
			line_par    <= 1'b0;
			field_start <= 1'b0;
			field_end   <= 1'b0;
		end
		else
		begin
			href_d      <= href;
			field_d     <= field_act;
			field_start <= field_act & ~field_d;
			field_end   <= ~field_act & field_d;
			if (field_act & ~field_d)
				line_par <= 1'b0;            // new field
			else if (field_act & href_rise)
				line_par <= ~line_par;
		end
	end

	//----------------------------------------
	// byte demux
	//----------------------------------------
	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
		begin
			byte_cnt <= 2'd0;
			pix_stb  <= 1'b0;
		end
		else
		begin
			pix_stb <= keep_now && (byte_cnt == 2'd2);   // strobe with Cr
			if (!keep_now)
				byte_cnt <= 2'd0;                  // restart outside kept line
			else
				byte_cnt <= byte_cnt + 2'd1;
		end
	end

	// sample latches, held until the next group overwrites them
	always_ff @(posedge clk_llc)
	begin
		if (keep_now)
		begin
			case (byte_cnt)
				2'd0:    cb <= vpo;
				2'd1:    y  <= vpo;
				2'd2:    cr <= vpo;
				default: ;                    // Y1 dropped, one pixel per group
			endcase
		end
	end

endmodule

// File: rtl/video_pkg.sv
// shared types and constants for the video capture path
// widths, YCbCr to RGB565 coefficients and the frame buffer FSM states
// imported by wildcard in every RTL block below the top level

package video_pkg;

	//----------------------------------------
	// data widths
	//----------------------------------------
	typedef logic [7:0]         byte_t;    // one Y, Cb or Cr sample
	typedef logic [9:0]         coef_t;    // unsigned 2.8 fixed point
	typedef logic signed [20:0] conv_t;    // product / sum in the colour math
	typedef logic [15:0]        rgb565_t;  // r[15:11] g[10:5] b[4:0]

	//----------------------------------------
	// conversion coefficients, 2.8 format
	//----------------------------------------
	localparam coef_t coef_y    = 10'b01_0010_1010;  // 1.164 -> 1.1640625
	localparam coef_t coef_cr_r = 10'b01_1001_1000;  // 1.596 -> 1.59375
	localparam coef_t coef_cr_g = 10'b00_1101_0000;  // 0.813 -> 0.8125
	localparam coef_t coef_cb_g = 10'b00_0110_0100;  // 0.392 -> 0.390625
	localparam coef_t coef_cb_b = 10'b10_0000_0100;  // 2.017 -> 2.015625

	// offsets are in the x4 domain, after the sample is shifted left by two
	localparam conv_t luma_offset   = 21'sd64;   // 16 << 2
	localparam conv_t chroma_offset = 21'sd512;  // 128 << 2

	//----------------------------------------
	// frame buffer arbitration
	//----------------------------------------
	typedef enum logic [1:0] {
		idle,         // memory free
		video_write,  // video pixel goes into the memory
		host_read     // memory read for the host
	} arb_state_t;

endpackage
